// ==== Bender.yml ====
package:
  name: dcache

sources:
  - verilog/dcache_pkg.sv
  - verilog/dcache_ifs.sv
  - verilog/ls_decode.sv
  - verilog/dcache_tag_banks.sv
  - verilog/dcache_exec.sv
  - verilog/load_result.sv
  - verilog/dcache_top.sv
  - target: simulation
    files:
      - bench/dcache_props.sv
      - bench/dcache_tb.sv

// ==== bench/dcache_props.sv ====
// Assumes one access in flight at a time; the hit latency check keys off mem_request two cycles on
`timescale 1ns/1ps

module dcache_props #(
    parameter logic [31:0] UNCACHED_BASE = 32'h8000_0000
) (
    input logic clk,
    input logic rst,
    input logic load_request,
    input logic load_ready,
    input logic store_request,
    input logic store_ready,
    input logic [31:0] load_addr,
    input logic data_valid,
    input logic mem_request,
    input logic mem_ack,
    input logic inv_valid,
    input logic inv_ack
);

    int fail_count = 0;

    //////////////////////////////
    // Request side

    a_load_ready: assert property (@(posedge clk) disable iff (rst) load_request |-> load_ready)
        else begin fail_count++; $error("load requested while load_ready low"); end

    a_store_ready: assert property (@(posedge clk) disable iff (rst) store_request |-> store_ready)
        else begin fail_count++; $error("store requested while store_ready low"); end

    // A hit never reaches the memory port, so the result is due one cycle after acceptance
    a_hit_latency: assert property (@(posedge clk) disable iff (rst)
        (load_request && load_ready && load_addr < UNCACHED_BASE) ##2 !mem_request
        |-> $past(data_valid))
        else begin fail_count++; $error("cache hit did not return data one cycle later"); end

    //////////////////////////////
    // Memory and invalidation ports

    a_req_held: assert property (@(posedge clk) disable iff (rst) mem_request && !mem_ack |=> mem_request)
        else begin fail_count++; $error("mem_request dropped before mem_ack"); end

    a_ack_with_req: assert property (@(posedge clk) disable iff (rst) mem_ack |-> mem_request)
        else begin fail_count++; $error("mem_ack seen without a memory request"); end

    a_inv_ack: assert property (@(posedge clk) disable iff (rst) inv_valid && !inv_ack |=> inv_ack)
        else begin fail_count++; $error("invalidation not acknowledged one cycle later"); end

    // Quiet and ready right out of reset
    a_reset_state: assert property (@(posedge clk) $fell(rst)
        |-> load_ready && store_ready && !mem_request && !data_valid && !inv_ack)
        else begin fail_count++; $error("outputs not in reset state after reset"); end

endmodule

bind dcache_top dcache_props #(.UNCACHED_BASE(UNCACHED_BASE)) u_props (
    .clk(clk), .rst(rst),
    .load_request(load_request), .load_ready(load_ready),
    .store_request(store_request), .store_ready(store_ready),
    .load_addr(load_addr), .data_valid(data_valid),
    .mem_request(mem_request), .mem_ack(mem_ack),
    .inv_valid(inv_valid), .inv_ack(inv_ack)
);

// ==== bench/dcache_tb.sv ====
// Memory acks 0 to 3 cycles late and streams fill words back to back; one access in flight at a time
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    logic clk = 1'b0;
    logic rst;
    logic tb_load_req;
    logic [31:0] tb_load_addr;
    logic fwd_load_req;
    logic fwd_armed;
    logic [31:0] fwd_addr;
    logic load_request;
    logic [31:0] load_addr;
    logic store_request;
    logic [31:0] store_addr;
    logic [3:0] store_be;
    logic [31:0] store_data;
    logic load_ready;
    logic store_ready;
    logic [31:0] data_out;
    logic data_valid;
    logic mem_request;
    logic [31:0] mem_addr;
    mem_op_t mem_op;
    logic [3:0] mem_be;
    logic [31:0] mem_data;
    logic mem_ack;
    logic fill_valid;
    logic [31:0] fill_data;
    logic inv_valid;
    logic [31:0] inv_addr;
    logic inv_ack;

    integer seed = 58666;
    int ack_delay = -1;
    int fill_left = 0;
    logic [29:0] fill_waddr;
    int line_reads = 0;
    int word_reads = 0;
    int writes = 0;
    logic [3:0] last_be;
    logic [31:0] last_waddr;
    int data_errors = 0;
    int req_errors = 0;
    logic [31:0] want;
    logic [31:0] exp_q [$];
    logic [31:0] shadow [logic [29:0]];

    always #10 clk = ~clk;

    // A load raised by the memory model lands in the store's ack cycle
    assign load_request = tb_load_req | fwd_load_req;
    assign load_addr = fwd_load_req ? fwd_addr : tb_load_addr;

    dcache_top #(
        .WAYS(WAYS),
        .LINES(LINES),
        .LINE_W(LINE_W),
        .UNCACHED_BASE(UNCACHED_BASE)
    ) u_dut (
        .clk(clk),
        .rst(rst),
        .load_request(load_request),
        .store_request(store_request),
        .load_addr(load_addr),
        .store_addr(store_addr),
        .store_be(store_be),
        .store_data(store_data),
        .load_ready(load_ready),
        .store_ready(store_ready),
        .data_out(data_out),
        .data_valid(data_valid),
        .mem_request(mem_request),
        .mem_addr(mem_addr),
        .mem_op(mem_op),
        .mem_be(mem_be),
        .mem_data(mem_data),
        .mem_ack(mem_ack),
        .fill_valid(fill_valid),
        .fill_data(fill_data),
        .inv_valid(inv_valid),
        .inv_addr(inv_addr),
        .inv_ack(inv_ack)
    );

    //////////////////////////////
    // Shadow memory

    function automatic logic [31:0] read_word(logic [29:0] waddr);
        if (shadow.exists(waddr)) begin
            return shadow[waddr];
        end
        return {2'b00, waddr} ^ 32'hA5A5_0000;
    endfunction

    function automatic void write_word(logic [29:0] waddr, logic [3:0] be, logic [31:0] data);
        logic [31:0] word;
        word = read_word(waddr);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                word[8*b +: 8] = data[8*b +: 8];
            end
        end
        shadow[waddr] = word;
    endfunction

    // Fill words have priority; nothing else is pending during a fill
    always @(negedge clk) begin
        mem_ack = 1'b0;
        fill_valid = 1'b0;
        fwd_load_req = 1'b0;
        if (fill_left > 0) begin
            fill_valid = 1'b1;
            fill_data = read_word(fill_waddr);
            fill_waddr = fill_waddr + 1'b1;
            fill_left--;
        end else if (mem_request === 1'b1) begin
            if (ack_delay < 0) begin
                ack_delay = $random(seed) & 3;
            end
            if (ack_delay == 0) begin
                mem_ack = 1'b1;
                ack_delay = -1;
                case (mem_op)
                    MEM_LINE_READ: begin
                        line_reads++;
                        fill_waddr = mem_addr[31:2];
                        fill_left = LINE_W;
                    end
                    MEM_WORD_READ: begin
                        word_reads++;
                        fill_waddr = mem_addr[31:2];
                        fill_left = 1;
                    end
                    MEM_WORD_WRITE: begin
                        writes++;
                        last_be = mem_be;
                        last_waddr = mem_addr;
                        write_word(mem_addr[31:2], mem_be, mem_data);
                        if (fwd_armed) begin
                            fwd_armed = 1'b0;
                            fwd_load_req = 1'b1;
                            exp_q.push_back(read_word(fwd_addr[31:2]));
                        end
                    end
                    default: begin
                        req_errors++;
                        $display("FAILED mem_op: got %h, not a known opcode", mem_op);
                    end
                endcase
            end else begin
                ack_delay--;
            end
        end
    end

    // Load results sampled mid-cycle
    always @(negedge clk) begin
        if (data_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                data_errors++;
                $display("data_valid raised with no load outstanding");
            end else begin
                want = exp_q.pop_front();
                assert (data_out === want) else begin
                    data_errors++;
                    $display("FAILED data_out: got %h expected %h", data_out, want);
                end
            end
        end
    end

    //////////////////////////////
    // Stimulus tasks

    task automatic report_counts();
        $display("Errors: data %0d, memory requests %0d, protocol %0d",
                 data_errors, req_errors, u_dut.u_props.fail_count);
    endtask

    task automatic give_up(string what);
        $display("Timeout while waiting for %s", what);
        report_counts();
        $display("test failed");
        $finish;
    endtask

    // Returns on a falling edge with the cache quiet
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) give_up("the cache to go idle");
        end while (!(load_ready && store_ready && !mem_request && exp_q.size() == 0));
        @(negedge clk);
    endtask

    task automatic check_load(logic [31:0] addr, int lines, int words);
        int line_base;
        int word_base;
        wait_idle();
        line_base = line_reads;
        word_base = word_reads;
        exp_q.push_back(read_word(addr[31:2]));
        tb_load_req = 1'b1;
        tb_load_addr = addr;
        @(negedge clk);
        tb_load_req = 1'b0;
        wait_idle();
        assert (line_reads - line_base == lines) else begin
            req_errors++;
            $display("FAILED line reads for %h: got %h expected %h",
                     addr, line_reads - line_base, lines);
        end
        assert (word_reads - word_base == words) else begin
            req_errors++;
            $display("FAILED word reads for %h: got %h expected %h",
                     addr, word_reads - word_base, words);
        end
    endtask

    // With forward set, a load to the same word follows in the ack cycle
    task automatic check_store(logic [31:0] addr, logic [3:0] be, logic [31:0] data,
                               logic forward);
        int base;
        wait_idle();
        base = writes;
        fwd_addr = addr;
        fwd_armed = forward;
        store_request = 1'b1;
        store_addr = addr;
        store_be = be;
        store_data = data;
        @(negedge clk);
        store_request = 1'b0;
        wait_idle();
        assert (writes - base == 1) else begin
            req_errors++;
            $display("FAILED word writes for %h: got %h expected 1", addr, writes - base);
        end
        assert (last_be == be) else begin
            req_errors++;
            $display("FAILED mem_be: got %h expected %h", last_be, be);
        end
        assert (last_waddr == {addr[31:2], 2'b00}) else begin
            req_errors++;
            $display("FAILED mem_addr: got %h expected %h", last_waddr, {addr[31:2], 2'b00});
        end
    endtask

    task automatic invalidate(logic [31:0] addr);
        int cycles;
        wait_idle();
        cycles = 0;
        inv_valid = 1'b1;
        inv_addr = addr;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) give_up("inv_ack");
        end while (!inv_ack);
        @(negedge clk);
        inv_valid = 1'b0;
    endtask

    //////////////////////////////
    // Test sequence

    initial begin
        rst = 1'b1;
        tb_load_req = 1'b0;
        tb_load_addr = '0;
        fwd_load_req = 1'b0;
        fwd_armed = 1'b0;
        fwd_addr = '0;
        store_request = 1'b0;
        store_addr = '0;
        store_be = '0;
        store_data = '0;
        mem_ack = 1'b0;
        fill_valid = 1'b0;
        fill_data = '0;
        inv_valid = 1'b0;
        inv_addr = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Misses at every word position, then hits on the same lines
        for (int i = 0; i < 4; i++) begin
            check_load(32'h0000_1000 + 32'(i) * 32'h50 + 32'(i * 4), 1, 0);
        end
        for (int i = 0; i < 4; i++) begin
            check_load(32'h0000_1000 + 32'(i) * 32'h50 + 32'(3 - i) * 4, 0, 0);
        end

        // Store hit updates the bank, store miss leaves it alone
        check_store(32'h0000_1004, 4'($random(seed)) | 4'b0001, $random(seed), 1'b0);
        check_load(32'h0000_1004, 0, 0);
        check_store(32'h0000_3008, 4'b1010, $random(seed), 1'b0);
        check_load(32'h0000_3008, 1, 0);

        // Loads issued while the store is still on the memory port
        check_store(32'h0000_1054, 4'b0110, $random(seed), 1'b1);
        check_store(32'h0000_4010, 4'b1001, $random(seed), 1'b1);
        check_store(32'h8000_0020, 4'b0011, $random(seed), 1'b1);

        // Uncacheable region never allocates
        check_load(32'h8000_0100, 0, 1);
        check_load(32'h8000_0100, 0, 1);
        check_store(32'h8000_0104, 4'b1100, $random(seed), 1'b0);
        check_load(32'h8000_0104, 0, 1);
        check_load(32'hFFFF_FFF0, 0, 1);

        // Boundary word and the word just below it
        check_load(UNCACHED_BASE, 0, 1);
        check_load(UNCACHED_BASE, 0, 1);
        check_load(UNCACHED_BASE - 32'd4, 1, 0);

        // Invalidated line misses again, its neighbors still hit
        invalidate(32'h0000_1050);
        check_load(32'h0000_1058, 1, 0);
        check_load(32'h0000_1058, 0, 0);
        check_load(32'h0000_10A8, 0, 0);

        wait_idle();
        report_counts();
        if (data_errors + req_errors + u_dut.u_props.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/dcache_pkg.sv
verilog/dcache_ifs.sv
verilog/ls_decode.sv
verilog/dcache_tag_banks.sv
verilog/dcache_exec.sv
verilog/load_result.sv
verilog/dcache_top.sv
bench/dcache_props.sv
bench/dcache_tb.sv

// ==== verilog/dcache_exec.sv ====
// Single outstanding miss; LINES and LINE_W must equal the dcache_pkg defaults used for widths
`timescale 1ns/1ps

module dcache_exec
    import dcache_pkg::*;
#(
    parameter int WAYS = dcache_pkg::WAYS,
    parameter int LINES = dcache_pkg::LINES,
    parameter int LINE_W = dcache_pkg::LINE_W
) (
    input logic clk,
    input logic rst,
    ls_stage_if.exec stage,
    lookup_if.exec look,
    output logic load_ready,
    output logic store_ready,
    output logic store_pending,
    output logic mem_request,
    output logic [31:0] mem_addr,
    output mem_op_t mem_op,
    output logic [3:0] mem_be,
    output logic [31:0] mem_data,
    input logic mem_ack,
    input logic fill_valid,
    input logic [31:0] fill_data,
    input logic inv_valid,
    input logic [31:0] inv_addr,
    output logic inv_ack
);

    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1;
    localparam int BANK_AW = LINE_ADDR_W + SUB_LINE_W;
    localparam logic [31:0] LINE_MASK = ~32'(LINE_W * 4 - 1);

    load_state_t load_state, load_next;
    store_state_t store_state, store_next;

    logic load_hit;
    logic [WAYS-1:0] load_hit_way;
    logic [WAYS-1:0] store_hit_way;
    logic load_ack;
    logic store_ack;
    logic arb_load_sel;
    logic q_push;
    logic q_pop;
    logic q_wr_ptr;
    logic [1:0] q_count;
    logic q_entry [2];
    logic fill_active;
    logic is_target_word;
    logic line_complete;
    logic [SUB_LINE_W-1:0] word_count;
    logic [WAYS-1:0] repl_way;
    logic [WAYS-1:0] fill_way_r;
    logic [WAY_W-1:0] hit_idx;
    logic [WAY_W-1:0] repl_idx;
    logic [WAY_W-1:0] fill_idx_r;
    logic [31:0] fill_word_r;
    logic [BANK_AW-1:0] rd_addr;
    logic [BANK_AW-1:0] fill_waddr;
    logic [BANK_AW-1:0] store_waddr;

    //////////////////////////////
    // Load and store FSMs

    always_ff @(posedge clk) begin
        if (rst) begin
            load_state <= LOAD_IDLE;
            store_state <= STORE_IDLE;
        end else begin
            load_state <= load_next;
            store_state <= store_next;
        end
    end

    always_comb begin
        load_next = load_state;
        case (load_state)
            LOAD_IDLE: if (stage.load_request) load_next = LOAD_HIT_CHECK;
            LOAD_HIT_CHECK: begin
                if (!load_hit) begin
                    load_next = LOAD_MEM_REQUEST;
                end else if (!stage.load_request) begin
                    load_next = LOAD_IDLE;
                end
            end
            LOAD_MEM_REQUEST: if (load_ack) load_next = LOAD_FILL;
            LOAD_FILL: if (line_complete) load_next = LOAD_IDLE;
            default: load_next = LOAD_IDLE;
        endcase
    end

    always_comb begin
        store_next = store_state;
        if (stage.store_request) begin
            store_next = STORE_MEM_REQUEST;
        end else if (store_ack) begin
            store_next = STORE_IDLE;
        end
    end

    assign store_pending = (store_state == STORE_MEM_REQUEST);
    assign load_ready = ((load_state == LOAD_IDLE) | load_hit) & (~store_pending | store_ack);
    assign store_ready = (~store_pending | store_ack) & ((load_state == LOAD_IDLE) | load_hit);

    //////////////////////////////
    // Order queue and memory port

    // Entry is 1 for a load, 0 for a store; head owns the port
    assign q_push = stage.load_request | stage.store_request;
    assign q_pop = mem_ack | load_hit;
    assign q_wr_ptr = 1'(q_count - 2'(q_pop));
    assign arb_load_sel = q_entry[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            q_count <= '0;
        end else begin
            q_count <= q_count + 2'(q_push) - 2'(q_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) q_entry[0] <= q_entry[1];
        if (q_push) q_entry[q_wr_ptr] <= stage.load_request;
    end

    assign load_ack = mem_ack & arb_load_sel;
    assign store_ack = mem_ack & ~arb_load_sel;

    assign mem_request = (load_state == LOAD_MEM_REQUEST) | store_pending;
    assign mem_be = stage.store_be_r;
    assign mem_data = stage.store_data_r;

    always_comb begin
        if (!arb_load_sel) begin
            mem_op = MEM_WORD_WRITE;
            mem_addr = {stage.store_addr_r[31:2], 2'b00};
        end else if (stage.load_uncached_r) begin
            mem_op = MEM_WORD_READ;
            mem_addr = {stage.load_addr_r[31:2], 2'b00};
        end else begin
            mem_op = MEM_LINE_READ;
            mem_addr = stage.load_addr_r & LINE_MASK;
        end
    end

    //////////////////////////////
    // Fill tracking

    assign fill_active = fill_valid & (load_state == LOAD_FILL);
    assign is_target_word = (stage.load_addr_r[2 +: SUB_LINE_W] == word_count)
                          | stage.load_uncached_r;
    assign line_complete = fill_active
                         & ((word_count == SUB_LINE_W'(LINE_W - 1)) | stage.load_uncached_r);
    assign look.fill_word_valid = fill_active & is_target_word;

    always_ff @(posedge clk) begin
        if (rst || stage.load_request) begin
            word_count <= '0;
        end else if (fill_active) begin
            word_count <= word_count + 1'b1;
        end
    end

    // Free-running one-hot cycler picks the victim way
    always_ff @(posedge clk) begin
        if (rst) begin
            repl_way <= WAYS'(1);
        end else begin
            repl_way <= (repl_way << 1) | (repl_way >> (WAYS - 1));
        end
    end

    always_comb begin
        hit_idx = '0;
        repl_idx = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (load_hit_way[w]) hit_idx = WAY_W'(w);
            if (repl_way[w]) repl_idx = WAY_W'(w);
        end
    end

    always_ff @(posedge clk) begin
        if (load_ack) begin
            fill_way_r <= repl_way;
            fill_idx_r <= repl_idx;
        end
        if (fill_active) fill_word_r <= fill_data;
    end

    assign look.hit = load_hit;
    assign look.sel_index = (load_state == LOAD_HIT_CHECK) ? hit_idx : fill_idx_r;

    dcache_tag_banks #(
        .WAYS(WAYS),
        .LINES(LINES)
    ) u_tag_banks (
        .clk(clk),
        .rst(rst),
        .lookup_addr(stage.load_addr_r),
        .lookup_req(stage.load_check),
        .fill_addr(stage.load_addr_r),
        .fill_req(load_ack & ~stage.load_uncached_r),
        .fill_way(repl_way),
        .store_addr_r(stage.store_addr_r),
        .store_req_r(store_pending),
        .inv_addr(inv_addr),
        .inv_valid(inv_valid),
        .load_hit(load_hit),
        .load_hit_way(load_hit_way),
        .store_hit_way(store_hit_way),
        .inv_ack(inv_ack)
    );

    //////////////////////////////
    // Data banks

    assign rd_addr = stage.load_addr_r[2 +: BANK_AW];
    assign fill_waddr = {stage.load_addr_r[2 + SUB_LINE_W +: LINE_ADDR_W], word_count};
    assign store_waddr = stage.store_addr_r[2 +: BANK_AW];

    for (genvar i = 0; i < WAYS; i++) begin : g_bank
        logic [31:0] bank [LINES * LINE_W];

        always_ff @(posedge clk) begin
            if (fill_active && fill_way_r[i] && !stage.load_uncached_r) begin
                bank[fill_waddr] <= fill_data;
            end
            // Store hit updated once, as memory takes the write
            if (store_ack && store_hit_way[i] && !stage.store_uncached_r) begin
                for (int b = 0; b < 4; b++) begin
                    if (stage.store_be_r[b]) begin
                        bank[store_waddr][8*b +: 8] <= stage.store_data_r[8*b +: 8];
                    end
                end
            end
        end

        // Uncached words bypass the bank
        assign look.bank_data[i] = stage.load_uncached_r ? fill_word_r : bank[rd_addr];
    end

endmodule

// ==== verilog/dcache_ifs.sv ====
// Internal stage and lookup bundles; lookup_if must be built with the same WAYS as the cache
`timescale 1ns/1ps

// Stage-2 load and store registers plus forwarding bytes
interface ls_stage_if;
    logic load_request;
    logic load_check;
    logic [31:0] load_addr_r;
    logic load_uncached_r;
    logic store_request;
    logic [31:0] store_addr_r;
    logic [3:0] store_be_r;
    logic [31:0] store_data_r;
    logic store_uncached_r;
    logic [3:0] fwd_be;
    logic [31:0] fwd_data;

    modport decode (
        output load_request, load_check, load_addr_r, load_uncached_r,
        output store_request, store_addr_r, store_be_r, store_data_r, store_uncached_r,
        output fwd_be, fwd_data
    );
    modport exec (
        input load_request, load_check, load_addr_r, load_uncached_r,
        input store_request, store_addr_r, store_be_r, store_data_r, store_uncached_r
    );
    modport result (
        input fwd_be, fwd_data
    );
endinterface

// Bank read words and way select for the result stage
interface lookup_if #(
    parameter int WAYS = dcache_pkg::WAYS
);
    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1;

    logic hit;
    logic [WAYS-1:0][31:0] bank_data;
    logic [WAY_W-1:0] sel_index;
    logic fill_word_valid;

    modport exec (output hit, bank_data, sel_index, fill_word_valid);
    modport result (input hit, bank_data, sel_index, fill_word_valid);
endinterface

// ==== verilog/dcache_pkg.sv ====
// Default cache geometry; LINES and LINE_W must stay powers of two and match what the top level passes down
package dcache_pkg;

    //////////////////////////////
    // Geometry defaults

    localparam int WAYS = 2;
    localparam int LINES = 32;
    localparam int LINE_W = 4;
    localparam logic [31:0] UNCACHED_BASE = 32'h8000_0000;

    // Address fields from the top are tag, index, word in line and byte
    localparam int LINE_ADDR_W = $clog2(LINES);
    localparam int SUB_LINE_W = $clog2(LINE_W);
    localparam int TAG_W = 32 - LINE_ADDR_W - SUB_LINE_W - 2;

    //////////////////////////////
    // State and opcode encodings

    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_HIT_CHECK,
        LOAD_MEM_REQUEST,
        LOAD_FILL
    } load_state_t;

    typedef enum logic {
        STORE_IDLE,
        STORE_MEM_REQUEST
    } store_state_t;

    // Request currently driven on the memory port
    typedef enum logic [1:0] {
        MEM_LINE_READ,
        MEM_WORD_READ,
        MEM_WORD_WRITE
    } mem_op_t;

endpackage

// ==== verilog/dcache_tag_banks.sv ====
// Tag widths come from dcache_pkg, so LINES must equal the package default; tags have no reset
`timescale 1ns/1ps

module dcache_tag_banks
    import dcache_pkg::*;
#(
    parameter int WAYS = dcache_pkg::WAYS,
    parameter int LINES = dcache_pkg::LINES
) (
    input logic clk,
    input logic rst,
    input logic [31:0] lookup_addr,
    input logic lookup_req,
    input logic [31:0] fill_addr,
    input logic fill_req,
    input logic [WAYS-1:0] fill_way,
    input logic [31:0] store_addr_r,
    input logic store_req_r,
    input logic [31:0] inv_addr,
    input logic inv_valid,
    output logic load_hit,
    output logic [WAYS-1:0] load_hit_way,
    output logic [WAYS-1:0] store_hit_way,
    output logic inv_ack
);

    localparam int IDX_LSB = SUB_LINE_W + 2;

    logic [TAG_W-1:0] tags [WAYS][LINES];
    logic [LINES-1:0] valid [WAYS];

    logic [LINE_ADDR_W-1:0] lookup_idx;
    logic [LINE_ADDR_W-1:0] fill_idx;
    logic [LINE_ADDR_W-1:0] store_idx;
    logic [LINE_ADDR_W-1:0] inv_idx;
    logic [TAG_W-1:0] lookup_tag;
    logic [TAG_W-1:0] fill_tag;
    logic [TAG_W-1:0] store_tag;
    logic [TAG_W-1:0] inv_tag;
    logic inv_start;

    assign lookup_idx = lookup_addr[IDX_LSB +: LINE_ADDR_W];
    assign fill_idx = fill_addr[IDX_LSB +: LINE_ADDR_W];
    assign store_idx = store_addr_r[IDX_LSB +: LINE_ADDR_W];
    assign inv_idx = inv_addr[IDX_LSB +: LINE_ADDR_W];
    assign lookup_tag = lookup_addr[31 -: TAG_W];
    assign fill_tag = fill_addr[31 -: TAG_W];
    assign store_tag = store_addr_r[31 -: TAG_W];
    assign inv_tag = inv_addr[31 -: TAG_W];

    // First cycle of an invalidation; ack follows on the next
    assign inv_start = inv_valid & ~inv_ack;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            load_hit_way[w] = lookup_req & valid[w][lookup_idx]
                            & (tags[w][lookup_idx] == lookup_tag);
            store_hit_way[w] = store_req_r & valid[w][store_idx]
                             & (tags[w][store_idx] == store_tag);
        end
    end

    assign load_hit = |load_hit_way;

    //////////////////////////////
    // Valid bits

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < WAYS; w++) begin
                valid[w] <= '0;
            end
            inv_ack <= 1'b0;
        end else begin
            inv_ack <= inv_start;
            for (int w = 0; w < WAYS; w++) begin
                if (inv_start && tags[w][inv_idx] == inv_tag) begin
                    valid[w][inv_idx] <= 1'b0;
                end
                if (fill_req && fill_way[w]) begin
                    valid[w][fill_idx] <= 1'b1;
                end
            end
        end
    end

    // Tag written when the line read is accepted
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (fill_req && fill_way[w]) begin
                tags[w][fill_idx] <= fill_tag;
            end
        end
    end

endmodule

// ==== verilog/dcache_top.sv ====
// Blocking write-through cache; one outstanding miss, and load and store never requested together
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
#(
    parameter int WAYS = dcache_pkg::WAYS,
    parameter int LINES = dcache_pkg::LINES,
    parameter int LINE_W = dcache_pkg::LINE_W,
    parameter logic [31:0] UNCACHED_BASE = dcache_pkg::UNCACHED_BASE
) (
    input logic clk,
    input logic rst,
    // Load/store unit side
    input logic load_request,
    input logic store_request,
    input logic [31:0] load_addr,
    input logic [31:0] store_addr,
    input logic [3:0] store_be,
    input logic [31:0] store_data,
    output logic load_ready,
    output logic store_ready,
    output logic [31:0] data_out,
    output logic data_valid,
    // Memory side
    output logic mem_request,
    output logic [31:0] mem_addr,
    output mem_op_t mem_op,
    output logic [3:0] mem_be,
    output logic [31:0] mem_data,
    input logic mem_ack,
    input logic fill_valid,
    input logic [31:0] fill_data,
    input logic inv_valid,
    input logic [31:0] inv_addr,
    output logic inv_ack
);

    logic store_pending;

    ls_stage_if stage_if ();
    lookup_if #(.WAYS(WAYS)) look_if ();

    ls_decode #(
        .UNCACHED_BASE(UNCACHED_BASE)
    ) u_decode (
        .clk(clk),
        .rst(rst),
        .load_request(load_request),
        .store_request(store_request),
        .load_addr(load_addr),
        .store_addr(store_addr),
        .store_be(store_be),
        .store_data(store_data),
        .store_pending(store_pending),
        .stage(stage_if.decode)
    );

    dcache_exec #(
        .WAYS(WAYS),
        .LINES(LINES),
        .LINE_W(LINE_W)
    ) u_exec (
        .clk(clk),
        .rst(rst),
        .stage(stage_if.exec),
        .look(look_if.exec),
        .load_ready(load_ready),
        .store_ready(store_ready),
        .store_pending(store_pending),
        .mem_request(mem_request),
        .mem_addr(mem_addr),
        .mem_op(mem_op),
        .mem_be(mem_be),
        .mem_data(mem_data),
        .mem_ack(mem_ack),
        .fill_valid(fill_valid),
        .fill_data(fill_data),
        .inv_valid(inv_valid),
        .inv_addr(inv_addr),
        .inv_ack(inv_ack)
    );

    load_result #(
        .WAYS(WAYS)
    ) u_result (
        .clk(clk),
        .rst(rst),
        .stage(stage_if.result),
        .look(look_if.result),
        .data_out(data_out),
        .data_valid(data_valid)
    );

endmodule

// ==== verilog/load_result.sv ====
// Forwarded bytes override bank data for every load, hit or miss
`timescale 1ns/1ps

module load_result #(
    parameter int WAYS = dcache_pkg::WAYS
) (
    input logic clk,
    input logic rst,
    ls_stage_if.result stage,
    lookup_if.result look,
    output logic [31:0] data_out,
    output logic data_valid
);

    logic [WAYS-1:0][31:0] banks;
    logic [31:0] bank_word;
    logic fill_word_valid_r;

    // Target fill word is readable from the bank one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_word_valid_r <= 1'b0;
        end else begin
            fill_word_valid_r <= look.fill_word_valid;
        end
    end

    assign banks = look.bank_data;
    assign bank_word = banks[look.sel_index];

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            data_out[8*b +: 8] = stage.fwd_be[b] ? stage.fwd_data[8*b +: 8]
                                                 : bank_word[8*b +: 8];
        end
    end

    assign data_valid = look.hit | fill_word_valid_r;

endmodule

// ==== verilog/ls_decode.sv ====
// One request per cycle; load and store must not be requested in the same cycle
`timescale 1ns/1ps

module ls_decode #(
    parameter logic [31:0] UNCACHED_BASE = dcache_pkg::UNCACHED_BASE
) (
    input logic clk,
    input logic rst,
    input logic load_request,
    input logic store_request,
    input logic [31:0] load_addr,
    input logic [31:0] store_addr,
    input logic [3:0] store_be,
    input logic [31:0] store_data,
    input logic store_pending,
    ls_stage_if.decode stage
);

    logic load_uncached;
    logic store_uncached;
    logic collision;

    assign load_uncached = (load_addr >= UNCACHED_BASE);
    assign store_uncached = (store_addr >= UNCACHED_BASE);

    // Same word as a store still waiting on the memory port
    assign collision = store_pending & (stage.store_addr_r[31:2] == load_addr[31:2]);

    assign stage.load_request = load_request;
    assign stage.store_request = store_request;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage.load_check <= 1'b0;
        end else begin
            stage.load_check <= load_request & ~load_uncached;
        end
    end

    //////////////////////////////
    // Stage-2 registers

    always_ff @(posedge clk) begin
        if (load_request) begin
            stage.load_addr_r <= load_addr;
            stage.load_uncached_r <= load_uncached;
            stage.fwd_be <= {4{collision}} & stage.store_be_r;
            stage.fwd_data <= stage.store_data_r;
        end
    end

    always_ff @(posedge clk) begin
        if (store_request) begin
            stage.store_addr_r <= store_addr;
            stage.store_be_r <= store_be;
            stage.store_data_r <= store_data;
            stage.store_uncached_r <= store_uncached;
        end
    end

endmodule
